// ==== logic/commit_pkg.sv ====
package commit_pkg;

    // 32-bit data or address word
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

    // decoded operation as seen at commit
    typedef enum logic [3:0] {
        OP_OTHER = 4'd0,
        OP_LB    = 4'd1,
        OP_LBU   = 4'd2,
        OP_LH    = 4'd3,
        OP_LHU   = 4'd4,
        OP_LW    = 4'd5,
        OP_SB    = 4'd6,
        OP_SH    = 4'd7,
        OP_SW    = 4'd8,
        OP_ERET  = 4'd9
    } decoded_op_t;

    // boot exception vector, general exception offset
    parameter word_t EXC_ENTRY_DEFAULT = 32'hBFC00380;

endpackage

// ==== logic/load_align.sv ====
`timescale 1ns/1ns

module load_align (
    input  commit_pkg::word_t       word,
    input  logic [1:0]              offset,
    input  commit_pkg::decoded_op_t op,
    output commit_pkg::word_t       value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // little-endian lanes within the word
    assign byte_sel = word[{offset, 3'b000} +: 8];
    assign half_sel = word[{offset[1], 4'b0000} +: 16];

    always_comb
    begin
        case (op)
            commit_pkg::OP_LB:
            begin
                value = {{24{byte_sel[7]}}, byte_sel};
            end
            commit_pkg::OP_LBU:
            begin
                value = {24'd0, byte_sel};
            end
            commit_pkg::OP_LH:
            begin
                value = {{16{half_sel[15]}}, half_sel};
            end
            commit_pkg::OP_LHU:
            begin
                value = {16'd0, half_sel};
            end
            default:
            begin
                // LW and everything else pass through
                value = word;
            end
        endcase
    end

    // misaligned halfwords must have trapped before commit
    always_comb
    begin
        if (op == commit_pkg::OP_LH || op == commit_pkg::OP_LHU)
        begin
            assert final (offset[0] == 1'b0)
            else $error("halfword load at odd offset %0d", offset);
        end
    end

endmodule

// ==== logic/lane_writeback.sv ====
`timescale 1ns/1ns

module lane_writeback (
    input  commit_pkg::word_t     load_value,
    input  commit_pkg::word_t     alu_result,
    input  commit_pkg::reg_addr_t destreg,
    input  logic                  regwrite,
    input  logic                  memtoreg,
    output commit_pkg::word_t     result,
    output commit_pkg::reg_addr_t bypass_destreg,
    output logic                  bypass_wen,
    output logic                  bypass_memtoreg
);

    logic dest_is_zero;

    assign dest_is_zero = (destreg == '0);

    // loads take the formatted memory word
    assign result = memtoreg ? load_value : alu_result;

    assign bypass_destreg  = destreg;
    assign bypass_memtoreg = memtoreg;

    // $zero is hardwired, never forward into it
    assign bypass_wen = regwrite & ~dest_is_zero;

endmodule

// ==== logic/load_data_hold.sv ====
`timescale 1ns/1ns

module load_data_hold (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              dmem_en,
    input  logic              dmem_data_ok,
    input  commit_pkg::word_t dmem_rd,
    output commit_pkg::word_t load_data,
    output logic              finish_cdata
);

    commit_pkg::word_t rd_held;
    logic              done;

    // a response early in a stall is kept until the stall drops
    always_ff @(posedge clk)
    begin
        if (rst || !stall)
        begin
            rd_held <= '0;
            done    <= 1'b0;
        end
        else
        begin
            if (dmem_data_ok)
            begin
                rd_held <= dmem_rd;
            end
            done <= done | dmem_data_ok;
        end
    end

    // live response wins over the held copy
    assign load_data = dmem_data_ok ? dmem_rd : rd_held;

    assign finish_cdata = ~dmem_en | dmem_data_ok | done;

    // an idle memory port never holds up the pipeline
    assert property (@(posedge clk) disable iff (rst)
        !dmem_en |-> finish_cdata)
    else $error("finish_cdata low with dmem_en low");

endmodule

// ==== logic/redirect_gen.sv ====
`timescale 1ns/1ns

module redirect_gen #(
    parameter commit_pkg::word_t exc_entry = commit_pkg::EXC_ENTRY_DEFAULT
) (
    input  logic                    exception_valid,
    input  commit_pkg::decoded_op_t lane1_op,
    input  commit_pkg::decoded_op_t lane0_op,
    input  commit_pkg::word_t       lane1_epc,
    input  commit_pkg::word_t       lane0_epc,
    input  logic                    lane1_branch,
    input  logic                    lane1_jump,
    input  logic                    lane1_jr,
    input  logic                    lane1_taken,
    input  logic                    lane1_pred_taken,
    input  commit_pkg::word_t       lane1_pcbranch,
    input  commit_pkg::word_t       lane1_pcjump,
    input  commit_pkg::word_t       lane1_srca,
    input  commit_pkg::word_t       lane1_pcplus4,
    input  commit_pkg::word_t       lane0_pcplus4,
    output logic                    redirect_exception,
    output logic                    redirect_eret,
    output logic                    redirect_branch,
    output logic                    redirect_jump,
    output logic                    redirect_jr,
    output commit_pkg::word_t       redirect_exc_pc,
    output commit_pkg::word_t       redirect_epc,
    output commit_pkg::word_t       redirect_pcbranch,
    output commit_pkg::word_t       redirect_pcjump,
    output commit_pkg::word_t       redirect_pcjr,
    output commit_pkg::word_t       commit_pc,
    output logic                    predict_wen,
    output logic                    predict_taken,
    output commit_pkg::word_t       predict_target
);

    logic lane1_eret;
    logic lane0_eret;
    logic direct_jump;

    assign lane1_eret  = (lane1_op == commit_pkg::OP_ERET);
    assign lane0_eret  = (lane0_op == commit_pkg::OP_ERET);
    assign direct_jump = lane1_jump & ~lane1_jr;

    assign redirect_exception = exception_valid;
    assign redirect_exc_pc    = exc_entry;

    // older lane owns the epc when both could claim it
    assign redirect_eret = lane1_eret | lane0_eret;
    assign redirect_epc  = lane1_eret ? lane1_epc : lane0_epc;

    // mispredict either way; a wrongly taken branch resumes at the delay slot's successor
    assign redirect_branch   = lane1_branch & (lane1_taken != lane1_pred_taken);
    assign redirect_pcbranch = lane1_pred_taken ? lane0_pcplus4 : lane1_pcbranch;

    assign redirect_jump   = lane1_jump & ~lane1_pred_taken;
    assign redirect_pcjump = lane1_pcjump;

    assign redirect_jr   = lane1_jr;
    assign redirect_pcjr = lane1_srca;

    // predictor is indexed by the control instruction's own pc
    assign commit_pc      = lane1_pcplus4 - 32'd4;
    assign predict_wen    = lane1_branch | direct_jump;
    assign predict_taken  = lane1_taken | direct_jump;
    assign predict_target = lane1_jump ? lane1_pcjump : lane1_pcbranch;

    always_comb
    begin
        assert final (!(lane1_branch && lane1_jump))
        else $error("lane 1 decoded as both branch and jump");
    end

endmodule

// ==== logic/commit_stage.sv ====
`timescale 1ns/1ns

module commit_stage #(
    parameter commit_pkg::word_t exc_entry = commit_pkg::EXC_ENTRY_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  commit_pkg::decoded_op_t lane1_op,
    input  commit_pkg::word_t       lane1_alu_result,
    input  commit_pkg::reg_addr_t   lane1_destreg,
    input  logic                    lane1_regwrite,
    input  logic                    lane1_memtoreg,
    input  logic                    lane1_memwrite,
    input  commit_pkg::word_t       lane1_pcplus4,
    input  commit_pkg::word_t       lane1_epc,
    input  commit_pkg::decoded_op_t lane0_op,
    input  commit_pkg::word_t       lane0_alu_result,
    input  commit_pkg::reg_addr_t   lane0_destreg,
    input  logic                    lane0_regwrite,
    input  logic                    lane0_memtoreg,
    input  logic                    lane0_memwrite,
    input  commit_pkg::word_t       lane0_pcplus4,
    input  commit_pkg::word_t       lane0_epc,
    input  logic                    lane1_branch,
    input  logic                    lane1_jump,
    input  logic                    lane1_jr,
    input  logic                    lane1_taken,
    input  logic                    lane1_pred_taken,
    input  commit_pkg::word_t       lane1_pcbranch,
    input  commit_pkg::word_t       lane1_pcjump,
    input  commit_pkg::word_t       lane1_srca,
    input  logic                    exception_valid,
    input  logic                    dmem_en,
    input  commit_pkg::word_t       dmem_addr,
    input  commit_pkg::word_t       dmem_rd,
    input  logic                    dmem_data_ok,
    output commit_pkg::word_t       lane1_result,
    output commit_pkg::word_t       lane0_result,
    output commit_pkg::reg_addr_t   bypass_destreg1,
    output commit_pkg::reg_addr_t   bypass_destreg0,
    output logic                    bypass_wen1,
    output logic                    bypass_wen0,
    output logic                    bypass_memtoreg1,
    output logic                    bypass_memtoreg0,
    output logic                    redirect_exception,
    output logic                    redirect_eret,
    output logic                    redirect_branch,
    output logic                    redirect_jump,
    output logic                    redirect_jr,
    output commit_pkg::word_t       redirect_exc_pc,
    output commit_pkg::word_t       redirect_epc,
    output commit_pkg::word_t       redirect_pcbranch,
    output commit_pkg::word_t       redirect_pcjump,
    output commit_pkg::word_t       redirect_pcjr,
    output commit_pkg::word_t       commit_pc,
    output logic                    predict_wen,
    output logic                    predict_taken,
    output commit_pkg::word_t       predict_target,
    output logic                    finish_cdata
);

    logic                    lane1_mem;
    logic                    lane0_mem;
    commit_pkg::decoded_op_t mem_op;
    commit_pkg::word_t       load_data;
    commit_pkg::word_t       load_value;

    assign lane1_mem = lane1_memtoreg | lane1_memwrite;
    assign lane0_mem = lane0_memtoreg | lane0_memwrite;

    // only one memory port, so lane 1 claims it first
    assign mem_op = lane1_mem ? lane1_op : lane0_op;

    load_data_hold hold (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .dmem_en      (dmem_en),
        .dmem_data_ok (dmem_data_ok),
        .dmem_rd      (dmem_rd),
        .load_data    (load_data),
        .finish_cdata (finish_cdata)
    );

    load_align align (
        .word   (load_data),
        .offset (dmem_addr[1:0]),
        .op     (mem_op),
        .value  (load_value)
    );

    lane_writeback lane1_wb (
        .load_value      (load_value),
        .alu_result      (lane1_alu_result),
        .destreg         (lane1_destreg),
        .regwrite        (lane1_regwrite),
        .memtoreg        (lane1_memtoreg),
        .result          (lane1_result),
        .bypass_destreg  (bypass_destreg1),
        .bypass_wen      (bypass_wen1),
        .bypass_memtoreg (bypass_memtoreg1)
    );

    lane_writeback lane0_wb (
        .load_value      (load_value),
        .alu_result      (lane0_alu_result),
        .destreg         (lane0_destreg),
        .regwrite        (lane0_regwrite),
        .memtoreg        (lane0_memtoreg),
        .result          (lane0_result),
        .bypass_destreg  (bypass_destreg0),
        .bypass_wen      (bypass_wen0),
        .bypass_memtoreg (bypass_memtoreg0)
    );

    redirect_gen #(
        .exc_entry (exc_entry)
    ) redirect (
        .exception_valid    (exception_valid),
        .lane1_op           (lane1_op),
        .lane0_op           (lane0_op),
        .lane1_epc          (lane1_epc),
        .lane0_epc          (lane0_epc),
        .lane1_branch       (lane1_branch),
        .lane1_jump         (lane1_jump),
        .lane1_jr           (lane1_jr),
        .lane1_taken        (lane1_taken),
        .lane1_pred_taken   (lane1_pred_taken),
        .lane1_pcbranch     (lane1_pcbranch),
        .lane1_pcjump       (lane1_pcjump),
        .lane1_srca         (lane1_srca),
        .lane1_pcplus4      (lane1_pcplus4),
        .lane0_pcplus4      (lane0_pcplus4),
        .redirect_exception (redirect_exception),
        .redirect_eret      (redirect_eret),
        .redirect_branch    (redirect_branch),
        .redirect_jump      (redirect_jump),
        .redirect_jr        (redirect_jr),
        .redirect_exc_pc    (redirect_exc_pc),
        .redirect_epc       (redirect_epc),
        .redirect_pcbranch  (redirect_pcbranch),
        .redirect_pcjump    (redirect_pcjump),
        .redirect_pcjr      (redirect_pcjr),
        .commit_pc          (commit_pc),
        .predict_wen        (predict_wen),
        .predict_taken      (predict_taken),
        .predict_target     (predict_target)
    );

    // issue never pairs two memory ops
    assert property (@(posedge clk) disable iff (rst) !(lane1_mem && lane0_mem))
    else $error("both lanes carry a memory operation");

endmodule

// ==== include/commit_model.svh ====
`ifndef COMMIT_MODEL_SVH
`define COMMIT_MODEL_SVH

// shift the addressed byte or halfword down to bit 0, then extend
function automatic commit_pkg::word_t exp_load_value(
    input commit_pkg::word_t       data,
    input logic [1:0]              offset,
    input commit_pkg::decoded_op_t op
);
    commit_pkg::word_t by_byte;
    commit_pkg::word_t by_half;
    by_byte = data >> (32'(offset) * 8);
    by_half = offset[1] ? (data >> 16) : data;
    case (op)
        commit_pkg::OP_LB:  return {{24{by_byte[7]}}, by_byte[7:0]};
        commit_pkg::OP_LBU: return {24'd0, by_byte[7:0]};
        commit_pkg::OP_LH:  return {{16{by_half[15]}}, by_half[15:0]};
        commit_pkg::OP_LHU: return {16'd0, by_half[15:0]};
        default:            return data;
    endcase
endfunction

// live response first, else whatever the stall captured
function automatic commit_pkg::word_t exp_load_data(
    input logic ok,
    input commit_pkg::word_t rd,
    input commit_pkg::word_t held
);
    return ok ? rd : held;
endfunction

function automatic logic exp_finish(input logic en, input logic ok, input logic done);
    return !en || ok || done;
endfunction

function automatic commit_pkg::word_t exp_result(
    input logic              memtoreg,
    input commit_pkg::word_t load_value,
    input commit_pkg::word_t alu_result
);
    return memtoreg ? load_value : alu_result;
endfunction

// register zero never forwards
function automatic logic exp_bypass_wen(input logic regwrite, input commit_pkg::reg_addr_t dest);
    return regwrite && (dest != 5'd0);
endfunction

function automatic logic exp_eret(input commit_pkg::decoded_op_t op1,
                                  input commit_pkg::decoded_op_t op0);
    return (op1 == commit_pkg::OP_ERET) || (op0 == commit_pkg::OP_ERET);
endfunction

// lane 1 is older and wins
function automatic commit_pkg::word_t exp_epc(
    input commit_pkg::decoded_op_t op1,
    input commit_pkg::word_t       epc1,
    input commit_pkg::word_t       epc0
);
    return (op1 == commit_pkg::OP_ERET) ? epc1 : epc0;
endfunction

function automatic logic exp_branch_redirect(input logic branch, input logic taken,
                                             input logic pred);
    return branch && (taken != pred);
endfunction

function automatic logic exp_predict_wen(input logic branch, input logic jump, input logic jr);
    return branch || (jump && !jr);
endfunction

function automatic logic exp_predict_taken(input logic taken, input logic jump, input logic jr);
    return taken || (jump && !jr);
endfunction

`endif

// ==== tests/commit_tb.sv ====
`timescale 1ns/1ns

module commit_tb;

    `include "commit_model.svh"

    localparam commit_pkg::word_t EXC_VECTOR = 32'h8000_0180;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int STALL_SEQUENCES = 200;
    localparam int CYCLE_LIMIT     = 3000;

    logic clk = 1'b0;
    logic rst;
    logic stall;
    commit_pkg::decoded_op_t lane1_op, lane0_op;
    commit_pkg::word_t lane1_alu_result, lane0_alu_result;
    commit_pkg::reg_addr_t lane1_destreg, lane0_destreg;
    logic lane1_regwrite, lane0_regwrite, lane1_memtoreg, lane0_memtoreg;
    logic lane1_memwrite, lane0_memwrite;
    commit_pkg::word_t lane1_pcplus4, lane0_pcplus4, lane1_epc, lane0_epc;
    logic lane1_branch, lane1_jump, lane1_jr, lane1_taken, lane1_pred_taken;
    commit_pkg::word_t lane1_pcbranch, lane1_pcjump, lane1_srca;
    logic exception_valid, dmem_en, dmem_data_ok;
    commit_pkg::word_t dmem_addr, dmem_rd;

    commit_pkg::word_t lane1_result, lane0_result;
    commit_pkg::reg_addr_t bypass_destreg1, bypass_destreg0;
    logic bypass_wen1, bypass_wen0, bypass_memtoreg1, bypass_memtoreg0;
    logic redirect_exception, redirect_eret, redirect_branch, redirect_jump, redirect_jr;
    commit_pkg::word_t redirect_exc_pc, redirect_epc, redirect_pcbranch;
    commit_pkg::word_t redirect_pcjump, redirect_pcjr, commit_pc, predict_target;
    logic predict_wen, predict_taken, finish_cdata;

    // model of the hold register
    commit_pkg::word_t held_word;
    logic held_done;
    int cycle_count = 0;

    commit_stage #(.exc_entry(EXC_VECTOR)) UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task pick_mem_op(input bit load_only, output commit_pkg::decoded_op_t op,
                     output logic memtoreg, output logic memwrite);
        logic [1:0] offset;
        begin
            memtoreg = load_only || ($urandom % 2 == 0);
            memwrite = !memtoreg;
            if (memtoreg)
            begin
                case ($urandom % 5)
                    0: op = commit_pkg::OP_LB;
                    1: op = commit_pkg::OP_LBU;
                    2: op = commit_pkg::OP_LH;
                    3: op = commit_pkg::OP_LHU;
                    default: op = commit_pkg::OP_LW;
                endcase
            end
            else
            begin
                case ($urandom % 3)
                    0: op = commit_pkg::OP_SB;
                    1: op = commit_pkg::OP_SH;
                    default: op = commit_pkg::OP_SW;
                endcase
            end
            // keep the address aligned to the access size
            case (op)
                commit_pkg::OP_LH, commit_pkg::OP_LHU, commit_pkg::OP_SH:
                    offset = {1'($urandom), 1'b0};
                commit_pkg::OP_LW, commit_pkg::OP_SW:
                    offset = 2'b00;
                default:
                    offset = 2'($urandom);
            endcase
            dmem_addr = {dmem_addr[31:2], offset};
        end
    endtask

    // mem_lane 0 means no memory op, 1 lane 1, 2 lane 0
    task randomize_lanes(input int mem_lane, input bit load_only);
        int ctrl;
        begin
            lane1_alu_result = $urandom;
            lane0_alu_result = $urandom;
            lane1_destreg = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
            lane0_destreg = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
            lane1_regwrite = 1'($urandom);
            lane0_regwrite = 1'($urandom);
            lane1_pcplus4 = $urandom & 32'hFFFF_FFFC;
            lane0_pcplus4 = $urandom & 32'hFFFF_FFFC;
            lane1_epc = $urandom;
            lane0_epc = $urandom;
            lane1_pcbranch = $urandom;
            lane1_pcjump = $urandom;
            lane1_srca = $urandom;
            dmem_addr = $urandom;
            lane1_op = ($urandom % 8 == 0) ? commit_pkg::OP_ERET : commit_pkg::OP_OTHER;
            lane0_op = ($urandom % 8 == 0) ? commit_pkg::OP_ERET : commit_pkg::OP_OTHER;
            lane1_memtoreg = 1'b0;
            lane1_memwrite = 1'b0;
            lane0_memtoreg = 1'b0;
            lane0_memwrite = 1'b0;
            if (mem_lane == 1)
                pick_mem_op(load_only, lane1_op, lane1_memtoreg, lane1_memwrite);
            else if (mem_lane == 2)
                pick_mem_op(load_only, lane0_op, lane0_memtoreg, lane0_memwrite);
            ctrl = $urandom % 4;
            lane1_branch = (ctrl == 1);
            lane1_jump = (ctrl >= 2);
            lane1_jr = (ctrl == 3);
            lane1_taken = 1'($urandom);
            lane1_pred_taken = 1'($urandom);
            exception_valid = ($urandom % 8 == 0);
        end
    endtask

    task advance_clock;
        begin
            @(posedge clk);
            if (rst || !stall)
            begin
                held_word = '0;
                held_done = 1'b0;
            end
            else
            begin
                if (dmem_data_ok)
                    held_word = dmem_rd;
                held_done = held_done | dmem_data_ok;
            end
            #2;
        end
    endtask

    task check_outputs;
        commit_pkg::word_t ldata;
        commit_pkg::word_t lval;
        commit_pkg::decoded_op_t mop;
        begin
            #16;
            ldata = exp_load_data(dmem_data_ok, dmem_rd, held_word);
            mop = (lane1_memtoreg || lane1_memwrite) ? lane1_op : lane0_op;
            lval = exp_load_value(ldata, dmem_addr[1:0], mop);
            check_value("lane1_result", lane1_result,
                        exp_result(lane1_memtoreg, lval, lane1_alu_result));
            check_value("lane0_result", lane0_result,
                        exp_result(lane0_memtoreg, lval, lane0_alu_result));
            check_value("bypass_destreg1", bypass_destreg1, lane1_destreg);
            check_value("bypass_destreg0", bypass_destreg0, lane0_destreg);
            check_value("bypass_wen1", bypass_wen1, exp_bypass_wen(lane1_regwrite, lane1_destreg));
            check_value("bypass_wen0", bypass_wen0, exp_bypass_wen(lane0_regwrite, lane0_destreg));
            check_value("bypass_memtoreg1", bypass_memtoreg1, lane1_memtoreg);
            check_value("bypass_memtoreg0", bypass_memtoreg0, lane0_memtoreg);
            check_value("redirect_exception", redirect_exception, exception_valid);
            check_value("redirect_exc_pc", redirect_exc_pc, EXC_VECTOR);
            check_value("redirect_eret", redirect_eret, exp_eret(lane1_op, lane0_op));
            check_value("redirect_epc", redirect_epc, exp_epc(lane1_op, lane1_epc, lane0_epc));
            check_value("redirect_branch", redirect_branch,
                        exp_branch_redirect(lane1_branch, lane1_taken, lane1_pred_taken));
            check_value("redirect_pcbranch", redirect_pcbranch,
                        lane1_pred_taken ? lane0_pcplus4 : lane1_pcbranch);
            check_value("redirect_jump", redirect_jump, lane1_jump && !lane1_pred_taken);
            check_value("redirect_pcjump", redirect_pcjump, lane1_pcjump);
            check_value("redirect_jr", redirect_jr, lane1_jr);
            check_value("redirect_pcjr", redirect_pcjr, lane1_srca);
            check_value("commit_pc", commit_pc, lane1_pcplus4 - 32'd4);
            check_value("predict_wen", predict_wen,
                        exp_predict_wen(lane1_branch, lane1_jump, lane1_jr));
            check_value("predict_taken", predict_taken,
                        exp_predict_taken(lane1_taken, lane1_jump, lane1_jr));
            check_value("predict_target", predict_target,
                        lane1_jump ? lane1_pcjump : lane1_pcbranch);
            check_value("finish_cdata", finish_cdata,
                        exp_finish(dmem_en, dmem_data_ok, held_done));
        end
    endtask

    // capture, hold with data_ok low, release, then one cycle past the release
    task run_stall_sequence;
        int hold_cycles;
        int i;
        begin
            hold_cycles = $urandom % 2;
            for (i = 0; i < hold_cycles + 3; i++)
            begin
                advance_clock;
                randomize_lanes(1 + ($urandom % 2), 1'b1);
                stall = (i <= hold_cycles);
                dmem_en = (i <= hold_cycles + 1) ? 1'b1 : 1'($urandom);
                dmem_data_ok = (i == 0);
                dmem_rd = $urandom;
                check_outputs;
            end
        end
    endtask

    initial
    begin
        void'($urandom(97));
        rst = 1'b1;
        stall = 1'b0;
        dmem_en = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rd = '0;
        randomize_lanes(0, 1'b0);
        repeat (4) advance_clock;
        rst = 1'b0;

        // idle port right after reset
        randomize_lanes(0, 1'b0);
        check_outputs;

        repeat (RANDOM_CYCLES)
        begin
            advance_clock;
            randomize_lanes($urandom % 3, 1'b0);
            stall = ($urandom % 8 == 0);
            dmem_en = ($urandom % 4 != 0);
            dmem_data_ok = 1'($urandom);
            dmem_rd = $urandom;
            check_outputs;
        end

        repeat (STALL_SEQUENCES) run_stall_sequence;

        $display("Test passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
logic/commit_pkg.sv
logic/load_align.sv
logic/lane_writeback.sv
logic/load_data_hold.sv
logic/redirect_gen.sv
logic/commit_stage.sv
tests/commit_tb.sv
